// File: compile.f
+incdir+verilog
verilog/rv_id_pkg.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_operand_fwd.sv
verilog/rv_imm_bpred.sv
verilog/rv_id_ex_reg.sv
verilog/rv_id_stage.sv
verification/rv_id_stage_assertions.sv
verification/rv_id_stage_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the ID stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing --assert -f compile.f --top-module rv_id_stage_tb \
  -Mdir obj_dir > build.log 2>&1 \
  && ./obj_dir/Vrv_id_stage_tb > sim.log 2>&1 \
  || { echo "Build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "=== FAIL ===" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
echo "Simulation passed, log in sim.log"
exit 0

// File: verification/rv_id_stage_assertions.sv
module rv_id_stage_assertions (
  input logic              clk,
  input logic              rst_n,
  input logic              flush,
  input logic              ex_valid,
  input logic              ex_ready,
  input rv_id_pkg::id_ex_t ex_pkt
);

  logic stalled;

  // Output offered but not taken this cycle
  assign stalled = ex_valid && !ex_ready;

  stall_holds_valid: assert property (@(posedge clk) disable iff (!rst_n)
    stalled && !flush |=> ex_valid)
    else $error("ex_valid dropped while stalled without flush");

  stall_holds_pkt: assert property (@(posedge clk) disable iff (!rst_n)
    stalled && !flush |=> $stable(ex_pkt))
    else $error("ex_pkt changed while stalled");

  reset_clears_valid: assert property (@(posedge clk) !rst_n |=> !ex_valid)
    else $error("ex_valid high in the cycle after reset");

endmodule

bind rv_id_ex_reg rv_id_stage_assertions id_ex_checks (
  .clk      (clk),
  .rst_n    (rst_n),
  .flush    (flush),
  .ex_valid (ex_valid),
  .ex_ready (ex_ready),
  .ex_pkt   (ex_pkt)
);

// File: verification/rv_id_stage_tb.sv
`include "rv_id_config.svh"

module rv_id_stage_tb;
  import rv_id_pkg::*;

  localparam int num_cycles = 3000;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       flush;
  logic       id_valid;
  fetch_pkt_t fetch;
  wb_src_t    mem_fwd;
  wb_src_t    wb_fwd;
  logic       ex_ready;
  logic       id_ready;
  logic       pred_taken;
  word_t      pred_target;
  logic       ex_valid;
  id_ex_t     ex_pkt;

  // Reference model state
  word_t       shadow [0:`RV_NREGS-1];
  id_ex_t      expected_q [$];
  logic        flush_seen;
  logic [15:0] lfsr_state = 16'd29212;
  int          errors;
  int          timeouts;
  int          n_in;
  int          n_out;

  always #10 clk = ~clk;

  rv_id_stage rv_id_stage_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .id_valid    (id_valid),
    .fetch       (fetch),
    .mem_fwd     (mem_fwd),
    .wb_fwd      (wb_fwd),
    .ex_ready    (ex_ready),
    .id_ready    (id_ready),
    .pred_taken  (pred_taken),
    .pred_target (pred_target),
    .ex_valid    (ex_valid),
    .ex_pkt      (ex_pkt)
  );

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned k = 0; k < n; k++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  // Register fields limited to x0..x7 so bypass hits are frequent
  function automatic logic [31:0] random_instr();
    logic [3:0] pick;
    logic [6:0] op;
    logic [6:0] f7;
    logic [4:0] r2;
    logic [4:0] r1;
    logic [2:0] f3;
    logic [4:0] rd;
    pick = 4'(rand_bits(4));
    if (pick >= 4'd14) begin
      // SYSTEM and MISC-MEM are not handled by this stage
      op = rand_bits(1) ? 7'b1110011 : 7'b0001111;
    end else begin
      case (pick % 4'd9)
        4'd0: op = `RV_OP_LUI;
        4'd1: op = `RV_OP_AUIPC;
        4'd2: op = `RV_OP_JAL;
        4'd3: op = `RV_OP_JALR;
        4'd4: op = `RV_OP_BRANCH;
        4'd5: op = `RV_OP_LOAD;
        4'd6: op = `RV_OP_STORE;
        4'd7: op = `RV_OP_IMM;
        default: op = `RV_OP_REG;
      endcase
    end
    f7 = 7'(rand_bits(7));
    r2 = 5'(rand_bits(3));
    r1 = 5'(rand_bits(3));
    f3 = 3'(rand_bits(3));
    rd = 5'(rand_bits(3));
    return {f7, r2, r1, f3, rd, op};
  endfunction

  // Register file read as seen in the cycle of a WB write
  function automatic word_t rf_read(input reg_addr_t a, input wb_src_t wb);
    if (a == '0) begin
      return '0;
    end
    if (wb.reg_write && wb.rd == a) begin
      return wb.data;
    end
    return shadow[a];
  endfunction

  function automatic word_t operand_val(input reg_addr_t a, input logic used,
                                        input wb_src_t mem, input wb_src_t wb);
    if (used && a != '0 && mem.reg_write && mem.rd == a) begin
      return mem.data;
    end
    return rf_read(a, wb);
  endfunction

  function automatic id_ex_t expect_pkt(input logic [31:0] w, input word_t pc,
                                        input wb_src_t mem, input wb_src_t wb);
    logic [11:0] cbits;
    word_t       imm_i;
    word_t       imm_s;
    word_t       imm_b;
    word_t       imm_u;
    word_t       imm_j;
    word_t       imm;
    logic        use1;
    logic        use2;
    id_ex_t      p;
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_u = {w[31:12], 12'b0};
    imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    // Control bit order is reg_write mem_read mem_write alu_a alu_b res br jal jalr trap
    case (w[6:0])
      `RV_OP_LUI:    {cbits, imm, use1, use2} = {12'b1_0_0_10_1_00_0_0_0_0, imm_u, 2'b00};
      `RV_OP_AUIPC:  {cbits, imm, use1, use2} = {12'b1_0_0_01_1_00_0_0_0_0, imm_u, 2'b00};
      `RV_OP_JAL:    {cbits, imm, use1, use2} = {12'b1_0_0_01_1_10_0_1_0_0, imm_j, 2'b00};
      `RV_OP_JALR:   {cbits, imm, use1, use2} = {12'b1_0_0_00_1_10_0_0_1_0, imm_i, 2'b10};
      `RV_OP_BRANCH: {cbits, imm, use1, use2} = {12'b0_0_0_00_0_00_1_0_0_0, imm_b, 2'b11};
      `RV_OP_LOAD:   {cbits, imm, use1, use2} = {12'b1_1_0_00_1_01_0_0_0_0, imm_i, 2'b10};
      `RV_OP_STORE:  {cbits, imm, use1, use2} = {12'b0_0_1_00_1_00_0_0_0_0, imm_s, 2'b11};
      `RV_OP_IMM:    {cbits, imm, use1, use2} = {12'b1_0_0_00_1_00_0_0_0_0, imm_i, 2'b10};
      `RV_OP_REG:    {cbits, imm, use1, use2} = {12'b1_0_0_00_0_00_0_0_0_0, imm_i, 2'b11};
      default:       {cbits, imm, use1, use2} = {12'b0_0_0_00_0_00_0_0_0_1, imm_i, 2'b00};
    endcase
    p.ctrl       = cbits;
    p.rd         = w[11:7];
    p.rs1        = w[19:15];
    p.rs2        = w[24:20];
    p.funct3     = w[14:12];
    p.funct7     = w[31:25];
    p.rs1_data   = operand_val(w[19:15], use1, mem, wb);
    p.rs2_data   = operand_val(w[24:20], use2, mem, wb);
    p.imm        = imm;
    p.pc         = pc;
    // Taken for JAL and for backward branches
    p.pred_taken = p.ctrl.is_jal || (p.ctrl.is_branch && imm[31]);
    return p;
  endfunction

  task automatic drive_random();
    id_valid          = (2'(rand_bits(2)) != 2'b00);
    ex_ready          = (2'(rand_bits(2)) != 2'b00);
    flush             = (4'(rand_bits(4)) == 4'h0);
    fetch.instr       = random_instr();
    fetch.pc          = {30'(rand_bits(30)), 2'b00};
    mem_fwd.reg_write = rand_bits(1) != 0;
    mem_fwd.rd        = 5'(rand_bits(3));
    mem_fwd.data      = rand_bits(32);
    wb_fwd.reg_write  = rand_bits(1) != 0;
    wb_fwd.rd         = 5'(rand_bits(3));
    wb_fwd.data       = rand_bits(32);
  endtask

  // Sampled at the falling edge before the model steps over the next rising edge
  task automatic check_and_model();
    id_ex_t exp;
    logic   exp_ready;
    exp_ready = (expected_q.size() == 0) || ex_ready;
    if (ex_valid !== (expected_q.size() != 0)) begin
      errors++;
      $display("Fail at %0t: ex_valid is %b, model holds %0d items", $time, ex_valid,
               expected_q.size());
    end
    if (id_ready !== exp_ready) begin
      errors++;
      $display("Fail at %0t: id_ready is %b, expected %b", $time, id_ready, exp_ready);
    end
    if (ex_valid && expected_q.size() != 0 && ex_pkt !== expected_q[0]) begin
      errors++;
      $display("Fail at %0t: ex_pkt %h, expected %h", $time, ex_pkt, expected_q[0]);
    end
    if (flush_seen && ex_pkt !== expect_pkt(`RV_NOP, '0, '0, '0)) begin
      errors++;
      $display("Fail at %0t: payload after flush is %h, not the NOP decode", $time, ex_pkt);
    end
    exp = expect_pkt(fetch.instr, fetch.pc, mem_fwd, wb_fwd);
    if (id_valid && (pred_taken !== exp.pred_taken || pred_target !== fetch.pc + exp.imm)) begin
      errors++;
      $display("Fail at %0t: prediction %b/%h, expected %b/%h", $time, pred_taken,
               pred_target, exp.pred_taken, fetch.pc + exp.imm);
    end
    flush_seen = flush;
    if (flush) begin
      expected_q.delete();
    end else begin
      if (expected_q.size() != 0 && ex_ready) begin
        void'(expected_q.pop_front());
        n_out++;
      end
      if (exp_ready && id_valid) begin
        expected_q.push_back(exp);
        n_in++;
      end
    end
    if (wb_fwd.reg_write && wb_fwd.rd != '0) begin
      shadow[wb_fwd.rd] = wb_fwd.data;
    end
  endtask

  initial begin
    int drain;
    rst_n      = 1'b0;
    flush      = 1'b0;
    id_valid   = 1'b0;
    ex_ready   = 1'b0;
    fetch      = '0;
    mem_fwd    = '0;
    wb_fwd     = '0;
    flush_seen = 1'b0;
    errors     = 0;
    timeouts   = 0;
    n_in       = 0;
    n_out      = 0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    if (ex_valid !== 1'b0) begin
      errors++;
      $display("Fail at %0t: ex_valid is %b after reset", $time, ex_valid);
    end

    // Give every register a known value through the WB port
    for (int r = 1; r < `RV_NREGS; r++) begin
      @(posedge clk);
      #1;
      wb_fwd.reg_write = 1'b1;
      wb_fwd.rd        = 5'(r);
      wb_fwd.data      = rand_bits(32);
      @(negedge clk);
      check_and_model();
    end

    for (int cyc = 0; cyc < num_cycles; cyc++) begin
      @(posedge clk);
      #1;
      drive_random();
      @(negedge clk);
      check_and_model();
    end

    // Drain the slot with execute always ready
    @(posedge clk);
    #1;
    id_valid          = 1'b0;
    flush             = 1'b0;
    ex_ready          = 1'b1;
    mem_fwd.reg_write = 1'b0;
    wb_fwd.reg_write  = 1'b0;
    drain             = 0;
    @(negedge clk);
    check_and_model();
    while (ex_valid && drain < 8) begin
      @(negedge clk);
      check_and_model();
      drain++;
    end
    if (ex_valid) begin
      timeouts++;
      $display("Timeout: ex_valid still high after %0d drain cycles", drain);
    end
    if (expected_q.size() != 0) begin
      errors++;
      $display("Fail at %0t: %0d accepted instructions never left the stage", $time,
               expected_q.size());
    end

    $display("Summary: %0d errors, %0d timeouts, %0d accepted, %0d delivered",
             errors, timeouts, n_in, n_out);
    if (errors == 0 && timeouts == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: verilog/rv_decoder.sv
`include "rv_id_config.svh"

module rv_decoder (
  input  rv_id_pkg::instr_u    instr,
  output rv_id_pkg::ctrl_t     ctrl,
  output rv_id_pkg::imm_kind_e imm_kind,
  output logic                 rs1_used,
  output logic                 rs2_used
);
  import rv_id_pkg::*;

  always_comb begin
    ctrl     = '0;
    imm_kind = kind_i;
    rs1_used = 1'b0;
    rs2_used = 1'b0;

    case (instr.r.opcode)
      `RV_OP_LUI: begin
        // zero + imm, so rs1 field is not a source
        ctrl.reg_write = 1'b1;
        ctrl.alu_a_src = 2'd2;
        ctrl.alu_b_src = 1'b1;
        imm_kind       = kind_u;
      end
      `RV_OP_AUIPC: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_a_src = 2'd1;
        ctrl.alu_b_src = 1'b1;
        imm_kind       = kind_u;
      end
      `RV_OP_JAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_a_src = 2'd1;
        ctrl.alu_b_src = 1'b1;
        ctrl.res_src   = 2'd2;
        ctrl.is_jal    = 1'b1;
        imm_kind       = kind_j;
      end
      `RV_OP_JALR: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_b_src = 1'b1;
        ctrl.res_src   = 2'd2;
        ctrl.is_jalr   = 1'b1;
        rs1_used       = 1'b1;
      end
      `RV_OP_BRANCH: begin
        // Compare rs1 against rs2, target comes from pc + imm
        ctrl.is_branch = 1'b1;
        imm_kind       = kind_b;
        rs1_used       = 1'b1;
        rs2_used       = 1'b1;
      end
      `RV_OP_LOAD: begin
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.alu_b_src = 1'b1;
        ctrl.res_src   = 2'd1;
        rs1_used       = 1'b1;
      end
      `RV_OP_STORE: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_b_src = 1'b1;
        imm_kind       = kind_s;
        rs1_used       = 1'b1;
        rs2_used       = 1'b1;
      end
      `RV_OP_IMM: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_b_src = 1'b1;
        rs1_used       = 1'b1;
      end
      `RV_OP_REG: begin
        ctrl.reg_write = 1'b1;
        rs1_used       = 1'b1;
        rs2_used       = 1'b1;
      end
      default: begin
        // Illegal opcode, no architectural side effects
        ctrl.trap = 1'b1;
      end
    endcase
  end

endmodule

// File: verilog/rv_id_config.svh
`ifndef RV_ID_CONFIG_SVH
`define RV_ID_CONFIG_SVH

// Datapath and register file geometry
`define RV_XLEN   32
`define RV_NREGS  32
`define RV_REG_AW 5

// RV32I base opcodes handled by the decode stage
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_IMM    7'b0010011
`define RV_OP_REG    7'b0110011

// ADDI x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif

// File: verilog/rv_id_ex_reg.sv
`include "rv_id_config.svh"

module rv_id_ex_reg (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              flush,
  input  logic              id_valid,
  input  rv_id_pkg::id_ex_t id_pkt,
  input  logic              ex_ready,
  output logic              id_ready,
  output logic              ex_valid,
  output rv_id_pkg::id_ex_t ex_pkt
);
  import rv_id_pkg::*;

  localparam instr_u nop_instr = `RV_NOP;

  id_ex_t nop_pkt;

  // Decode of ADDI x0, x0, 0 loaded as the bubble payload
  always_comb begin
    nop_pkt                = '0;
    nop_pkt.ctrl.reg_write = 1'b1;
    nop_pkt.ctrl.alu_b_src = 1'b1;
    nop_pkt.rd             = nop_instr.i.rd;
    nop_pkt.rs1            = nop_instr.i.rs1;
    nop_pkt.rs2            = nop_instr.r.rs2;
    nop_pkt.funct3         = nop_instr.i.funct3;
    nop_pkt.funct7         = nop_instr.r.funct7;
    nop_pkt.imm            = {{(`RV_XLEN-12){nop_instr.i.imm12[11]}}, nop_instr.i.imm12};
  end

  // Slot is free when empty or draining this cycle
  assign id_ready = !ex_valid || ex_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_valid <= 1'b0;
    end else if (flush) begin
      ex_valid <= 1'b0;
    end else if (id_ready) begin
      ex_valid <= id_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (flush) begin
      ex_pkt <= nop_pkt;
    end else if (id_ready) begin
      ex_pkt <= id_pkt;
    end
  end

endmodule

// File: verilog/rv_id_pkg.sv
`include "rv_id_config.svh"

package rv_id_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [`RV_REG_AW-1:0] reg_addr_t;

  // Field views of one instruction word
  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_view_t;

  typedef struct packed {
    logic [11:0] imm12;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_view_t;

  // B immediates are scattered over the same bits as S
  typedef struct packed {
    logic [6:0] imm_hi;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_view_t;

  // J immediates are scattered over the same bits as U
  typedef struct packed {
    logic [19:0] imm20;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } u_view_t;

  typedef union packed {
    r_view_t r;
    i_view_t i;
    s_view_t s;
    u_view_t u;
  } instr_u;

  typedef enum logic [2:0] {
    kind_i,
    kind_s,
    kind_b,
    kind_u,
    kind_j
  } imm_kind_e;

  typedef struct packed {
    instr_u instr;
    word_t  pc;
  } fetch_pkt_t;

  // Register write from a later stage, also used as a bypass source
  typedef struct packed {
    logic      reg_write;
    reg_addr_t rd;
    word_t     data;
  } wb_src_t;

  // alu_a_src is 0 for rs1, 1 for pc, 2 for zero
  // alu_b_src is 0 for rs2, 1 for imm
  // res_src is 0 for ALU, 1 for load data, 2 for pc + 4
  typedef struct packed {
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    logic [1:0] alu_a_src;
    logic       alu_b_src;
    logic [1:0] res_src;
    logic       is_branch;
    logic       is_jal;
    logic       is_jalr;
    logic       trap;
  } ctrl_t;

  typedef struct packed {
    ctrl_t      ctrl;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      imm;
    word_t      pc;
    logic       pred_taken;
  } id_ex_t;

endpackage

// File: verilog/rv_id_stage.sv
module rv_id_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  flush,
  input  logic                  id_valid,
  input  rv_id_pkg::fetch_pkt_t fetch,
  input  rv_id_pkg::wb_src_t    mem_fwd,
  input  rv_id_pkg::wb_src_t    wb_fwd,
  input  logic                  ex_ready,
  output logic                  id_ready,
  output logic                  pred_taken,
  output rv_id_pkg::word_t      pred_target,
  output logic                  ex_valid,
  output rv_id_pkg::id_ex_t     ex_pkt
);
  import rv_id_pkg::*;

  ctrl_t     ctrl;
  imm_kind_e imm_kind;
  logic      rs1_used;
  logic      rs2_used;
  reg_addr_t rs1;
  reg_addr_t rs2;
  word_t     rf_rs1_data;
  word_t     rf_rs2_data;
  word_t     rs1_val;
  word_t     rs2_val;
  word_t     imm;
  id_ex_t    id_pkt;

  // Register fields sit at fixed positions in every format
  assign rs1 = fetch.instr.r.rs1;
  assign rs2 = fetch.instr.r.rs2;

  rv_decoder decoder_inst (
    .instr    (fetch.instr),
    .ctrl     (ctrl),
    .imm_kind (imm_kind),
    .rs1_used (rs1_used),
    .rs2_used (rs2_used)
  );

  rv_regfile regfile_inst (
    .clk      (clk),
    .rs1      (rs1),
    .rs2      (rs2),
    .wb       (wb_fwd),
    .rs1_data (rf_rs1_data),
    .rs2_data (rf_rs2_data)
  );

  rv_operand_fwd operand_fwd_inst (
    .rs1         (rs1),
    .rs2         (rs2),
    .rs1_used    (rs1_used),
    .rs2_used    (rs2_used),
    .rf_rs1_data (rf_rs1_data),
    .rf_rs2_data (rf_rs2_data),
    .mem_fwd     (mem_fwd),
    .wb_fwd      (wb_fwd),
    .rs1_val     (rs1_val),
    .rs2_val     (rs2_val)
  );

  rv_imm_bpred imm_bpred_inst (
    .fetch       (fetch),
    .imm_kind    (imm_kind),
    .is_branch   (ctrl.is_branch),
    .is_jal      (ctrl.is_jal),
    .imm         (imm),
    .pred_taken  (pred_taken),
    .pred_target (pred_target)
  );

  always_comb begin
    id_pkt.ctrl       = ctrl;
    id_pkt.rd         = fetch.instr.r.rd;
    id_pkt.rs1        = rs1;
    id_pkt.rs2        = rs2;
    id_pkt.funct3     = fetch.instr.r.funct3;
    id_pkt.funct7     = fetch.instr.r.funct7;
    id_pkt.rs1_data   = rs1_val;
    id_pkt.rs2_data   = rs2_val;
    id_pkt.imm        = imm;
    id_pkt.pc         = fetch.pc;
    id_pkt.pred_taken = pred_taken;
  end

  rv_id_ex_reg id_ex_reg_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .flush    (flush),
    .id_valid (id_valid),
    .id_pkt   (id_pkt),
    .ex_ready (ex_ready),
    .id_ready (id_ready),
    .ex_valid (ex_valid),
    .ex_pkt   (ex_pkt)
  );

endmodule

// File: verilog/rv_imm_bpred.sv
`include "rv_id_config.svh"

module rv_imm_bpred (
  input  rv_id_pkg::fetch_pkt_t fetch,
  input  rv_id_pkg::imm_kind_e  imm_kind,
  input  logic                  is_branch,
  input  logic                  is_jal,
  output rv_id_pkg::word_t      imm,
  output logic                  pred_taken,
  output rv_id_pkg::word_t      pred_target
);
  import rv_id_pkg::*;

  instr_u instr;
  logic   sign;

  assign instr = fetch.instr;
  // Bit 31 is the sign of every immediate format
  assign sign  = instr.r.funct7[6];

  always_comb begin
    case (imm_kind)
      kind_i: imm = {{(`RV_XLEN-12){sign}}, instr.i.imm12};
      kind_s: imm = {{(`RV_XLEN-12){sign}}, instr.s.imm_hi, instr.s.imm_lo};
      kind_b: begin
        imm = {{(`RV_XLEN-12){sign}}, instr.s.imm_lo[0], instr.s.imm_hi[5:0],
               instr.s.imm_lo[4:1], 1'b0};
      end
      kind_u: imm = {instr.u.imm20, 12'b0};
      kind_j: begin
        imm = {{(`RV_XLEN-20){sign}}, instr.u.imm20[7:0], instr.u.imm20[8],
               instr.u.imm20[18:9], 1'b0};
      end
      default: imm = '0;
    endcase
  end

  // Static BTFNT, JAL always taken, JALR left to execute
  assign pred_taken  = is_jal || (is_branch && imm[`RV_XLEN-1]);
  assign pred_target = fetch.pc + imm;

endmodule

// File: verilog/rv_operand_fwd.sv
module rv_operand_fwd (
  input  rv_id_pkg::reg_addr_t rs1,
  input  rv_id_pkg::reg_addr_t rs2,
  input  logic                 rs1_used,
  input  logic                 rs2_used,
  input  rv_id_pkg::word_t     rf_rs1_data,
  input  rv_id_pkg::word_t     rf_rs2_data,
  input  rv_id_pkg::wb_src_t   mem_fwd,
  input  rv_id_pkg::wb_src_t   wb_fwd,
  output rv_id_pkg::word_t     rs1_val,
  output rv_id_pkg::word_t     rs2_val
);
  import rv_id_pkg::*;

  // Youngest producer wins, MEM ahead of WB
  function automatic word_t bypass(
    input reg_addr_t src,
    input logic      used,
    input word_t     rf_val,
    input wb_src_t   mem,
    input wb_src_t   wb
  );
    word_t value;
    value = rf_val;
    if (used && src != '0) begin
      if (mem.reg_write && mem.rd == src) begin
        value = mem.data;
      end else if (wb.reg_write && wb.rd == src) begin
        value = wb.data;
      end
    end
    return value;
  endfunction

  assign rs1_val = bypass(rs1, rs1_used, rf_rs1_data, mem_fwd, wb_fwd);
  assign rs2_val = bypass(rs2, rs2_used, rf_rs2_data, mem_fwd, wb_fwd);

endmodule

// File: verilog/rv_regfile.sv
`include "rv_id_config.svh"

module rv_regfile (
  input  logic                 clk,
  input  rv_id_pkg::reg_addr_t rs1,
  input  rv_id_pkg::reg_addr_t rs2,
  input  rv_id_pkg::wb_src_t   wb,
  output rv_id_pkg::word_t     rs1_data,
  output rv_id_pkg::word_t     rs2_data
);
  import rv_id_pkg::*;

  // x0 has no storage
  word_t regs [1:`RV_NREGS-1];

  // Same-cycle write returns the new data
  function automatic word_t read_port(input reg_addr_t addr);
    word_t value;
    if (addr == '0) begin
      value = '0;
    end else if (wb.reg_write && wb.rd == addr) begin
      value = wb.data;
    end else begin
      value = regs[addr];
    end
    return value;
  endfunction

  always_ff @(posedge clk) begin
    if (wb.reg_write && wb.rd != '0) begin
      regs[wb.rd] <= wb.data;
    end
  end

  always_comb begin
    rs1_data = read_port(rs1);
    rs2_data = read_port(rs2);
  end

endmodule
